// ==== hdl/dot_cfg_pkg.sv ====
// Dot product engine data types
package dot_cfg_pkg;

    // ==============================
    // Element and result types
    // ==============================

    // Q16.16 vector element, one SDRAM word
    typedef logic signed [31:0] elem_t;

    // Lane product and running sum, two words wide
    typedef logic signed [63:0] acc_t;

    // SDRAM word address
    typedef logic [23:0] word_addr_t;

    // Vector length or element index
    typedef logic [9:0] vec_len_t;

    // ==============================
    // Default sizes
    // ==============================

    // Depth of each on-chip vector buffer
    localparam int DEFAULT_MAX_LENGTH = 512;

    // Multiply lanes working side by side
    localparam int DEFAULT_NUM_LANES = 2;

endpackage

// ==== hdl/dot_regmap_pkg.sv ====
// Dot product register map
package dot_regmap_pkg;

    // ==============================
    // Byte offsets
    // ==============================

    localparam logic [7:0] REG_CTRL      = 8'h00;
    localparam logic [7:0] REG_LENGTH    = 8'h04;
    localparam logic [7:0] REG_RESULT_LO = 8'h08;
    localparam logic [7:0] REG_RESULT_HI = 8'h0C;
    localparam logic [7:0] REG_ADDR_A    = 8'h10;
    localparam logic [7:0] REG_ADDR_B    = 8'h14;

    // ==============================
    // CTRL bits
    // ==============================

    // Write side, start a run
    localparam int CTRL_START_BIT     = 0;
    // Skip the B fetch and reuse the buffer contents
    localparam int CTRL_CACHED_B_BIT  = 1;
    // Fetch B only and clear the result
    localparam int CTRL_PRELOAD_B_BIT = 2;

    // Read side, engine running
    localparam int STATUS_BUSY_BIT = 0;

endpackage

// ==== hdl/dot_reg_block.sv ====
// CPU register file
`timescale 1ns/1ps

module dot_reg_block (
    input  logic                    clk,
    input  logic                    reset_n,
    // Register bus
    input  logic                    reg_valid,
    input  logic                    reg_write,
    input  logic [7:0]              reg_addr,
    input  logic [31:0]             reg_wdata,
    output logic [31:0]             reg_rdata,
    output logic                    reg_ready,
    // Engine status
    input  logic                    busy,
    input  dot_cfg_pkg::acc_t       acc_value,
    // Run request and settings
    output logic                    start_req,
    output logic [1:0]              ctrl_mode,
    output dot_cfg_pkg::vec_len_t   vec_length,
    output dot_cfg_pkg::word_addr_t addr_a,
    output dot_cfg_pkg::word_addr_t addr_b
);
    import dot_cfg_pkg::*;
    import dot_regmap_pkg::*;

    // Set once a write has acted, held until reg_valid drops
    logic access_done;
    logic wr_fire;

    // Bus never stalls
    assign reg_ready = reg_valid;
    assign wr_fire   = reg_valid && reg_write && !access_done;

    // Start goes straight to the sequencer, which decides on acceptance
    assign start_req = wr_fire && (reg_addr == REG_CTRL) && reg_wdata[CTRL_START_BIT];
    // Bit 1 preload, bit 0 cached B
    assign ctrl_mode = {reg_wdata[CTRL_PRELOAD_B_BIT], reg_wdata[CTRL_CACHED_B_BIT]};

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            access_done <= 1'b0;
            vec_length  <= '0;
            addr_a      <= '0;
            addr_b      <= '0;
        end else begin
            if (!reg_valid) begin
                access_done <= 1'b0;
            end else if (wr_fire) begin
                access_done <= 1'b1;
            end
            // Fields keep only their low bits
            if (wr_fire) begin
                case (reg_addr)
                    REG_LENGTH: vec_length <= vec_len_t'(reg_wdata);
                    REG_ADDR_A: addr_a     <= word_addr_t'(reg_wdata);
                    REG_ADDR_B: addr_b     <= word_addr_t'(reg_wdata);
                    default: ;
                endcase
            end
        end
    end

    // ==============================
    // Read multiplexer
    // ==============================

    always_comb begin
        reg_rdata = '0;
        case (reg_addr)
            REG_CTRL:      reg_rdata[STATUS_BUSY_BIT] = busy;
            REG_LENGTH:    reg_rdata = 32'(vec_length);
            REG_RESULT_LO: reg_rdata = acc_value[31:0];
            REG_RESULT_HI: reg_rdata = acc_value[63:32];
            REG_ADDR_A:    reg_rdata = 32'(addr_a);
            REG_ADDR_B:    reg_rdata = 32'(addr_b);
            // Unmapped offsets read zero
            default:       reg_rdata = '0;
        endcase
    end

endmodule

// ==== hdl/dot_dma_sequencer.sv ====
// Fetch and compute sequencer
`timescale 1ns/1ps

module dot_dma_sequencer #(
    parameter int MAX_LENGTH = dot_cfg_pkg::DEFAULT_MAX_LENGTH
) (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    start_req,
    input  logic [1:0]              ctrl_mode,
    input  dot_cfg_pkg::vec_len_t   vec_length,
    input  dot_cfg_pkg::word_addr_t addr_a,
    input  dot_cfg_pkg::word_addr_t addr_b,
    input  logic [31:0]             burst_data,
    input  logic                    burst_data_valid,
    input  logic                    burst_data_done,
    input  logic                    acc_done,
    output logic                    busy,
    output logic                    burst_rd,
    output logic [24:0]             burst_addr,
    output logic [10:0]             burst_len,
    output logic                    buf_wr_en,
    output logic                    buf_wr_sel_b,
    output dot_cfg_pkg::vec_len_t   buf_wr_idx,
    output dot_cfg_pkg::elem_t      buf_wr_data,
    output logic                    compute_start,
    output logic                    result_clear
);
    import dot_cfg_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE, S_REQ_A, S_WAIT_A, S_REQ_B, S_WAIT_B, S_COMPUTE, S_DONE
    } state_t;

    state_t   state;
    // Mode bits latched at acceptance
    logic     use_cached_b;
    logic     preload_b;
    vec_len_t fetch_idx;

    assign busy = (state != S_IDLE);

    // Request strobe lasts exactly the one REQ cycle
    assign burst_rd   = (state == S_REQ_A) || (state == S_REQ_B);
    // Word address and length, each with a zero bit appended
    assign burst_addr = {(state == S_REQ_B) ? addr_b : addr_a, 1'b0};
    assign burst_len  = {vec_length, 1'b0};

    // Arriving words go in order to the selected buffer
    assign buf_wr_en    = burst_data_valid && ((state == S_WAIT_A) || (state == S_WAIT_B));
    assign buf_wr_sel_b = (state == S_WAIT_B);
    assign buf_wr_idx   = fetch_idx;
    assign buf_wr_data  = elem_t'(burst_data);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state         <= S_IDLE;
            use_cached_b  <= 1'b0;
            preload_b     <= 1'b0;
            fetch_idx     <= '0;
            compute_start <= 1'b0;
            result_clear  <= 1'b0;
        end else begin
            compute_start <= 1'b0;
            result_clear  <= 1'b0;
            if (buf_wr_en) begin
                fetch_idx <= fetch_idx + 1'b1;
            end
            case (state)
                S_IDLE: begin
                    // Start while running never reaches here
                    if (start_req) begin
                        use_cached_b <= ctrl_mode[0];
                        preload_b    <= ctrl_mode[1];
                        // Preload clears the result up front
                        result_clear <= ctrl_mode[1];
                        state        <= ctrl_mode[1] ? S_REQ_B : S_REQ_A;
                    end
                end
                S_REQ_A: begin
                    fetch_idx <= '0;
                    state     <= S_WAIT_A;
                end
                S_WAIT_A: begin
                    if (burst_data_done) begin
                        compute_start <= use_cached_b;
                        state         <= use_cached_b ? S_COMPUTE : S_REQ_B;
                    end
                end
                S_REQ_B: begin
                    fetch_idx <= '0;
                    state     <= S_WAIT_B;
                end
                S_WAIT_B: begin
                    if (burst_data_done) begin
                        compute_start <= !preload_b;
                        state         <= preload_b ? S_DONE : S_COMPUTE;
                    end
                end
                S_COMPUTE: begin
                    if (acc_done) begin
                        state <= S_DONE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Back-to-back requests would start a second burst
    a_burst_rd_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        burst_rd |=> !burst_rd);

    // Every word must fit the feeder buffers
    a_wr_idx_range: assert property (@(posedge clk) disable iff (!reset_n)
        buf_wr_en |-> (int'(buf_wr_idx) < MAX_LENGTH));

endmodule

// ==== hdl/operand_feeder.sv ====
// Vector buffers and lane operand issue
`timescale 1ns/1ps

module operand_feeder #(
    parameter int MAX_LENGTH = dot_cfg_pkg::DEFAULT_MAX_LENGTH,
    parameter int NUM_LANES  = dot_cfg_pkg::DEFAULT_NUM_LANES
) (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  buf_wr_en,
    input  logic                  buf_wr_sel_b,
    input  dot_cfg_pkg::vec_len_t buf_wr_idx,
    input  dot_cfg_pkg::elem_t    buf_wr_data,
    input  logic                  compute_start,
    input  dot_cfg_pkg::vec_len_t vec_length,
    output logic                  lane_valid,
    output logic                  lane_last,
    output dot_cfg_pkg::elem_t    lane_a [NUM_LANES],
    output dot_cfg_pkg::elem_t    lane_b [NUM_LANES]
);
    import dot_cfg_pkg::*;

    localparam int IDX_W = $clog2(MAX_LENGTH);

    elem_t       a_buf [MAX_LENGTH];
    elem_t       b_buf [MAX_LENGTH];
    logic        issuing;
    vec_len_t    cmp_idx;
    logic [10:0] next_idx;
    logic        last_grp;

    // Final group once the next start reaches the length, so length 0 gives one group
    assign next_idx = 11'(cmp_idx) + 11'(NUM_LANES);
    assign last_grp = (next_idx >= 11'(vec_length));

    always_ff @(posedge clk) begin
        if (buf_wr_en) begin
            if (buf_wr_sel_b) begin
                b_buf[buf_wr_idx[IDX_W-1:0]] <= buf_wr_data;
            end else begin
                a_buf[buf_wr_idx[IDX_W-1:0]] <= buf_wr_data;
            end
        end
    end

    // One group per cycle from compute_start on
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            issuing    <= 1'b0;
            cmp_idx    <= '0;
            lane_valid <= 1'b0;
            lane_last  <= 1'b0;
        end else begin
            lane_valid <= issuing;
            lane_last  <= issuing && last_grp;
            if (compute_start) begin
                issuing <= 1'b1;
                cmp_idx <= '0;
            end else if (issuing) begin
                cmp_idx <= vec_len_t'(next_idx);
                issuing <= !last_grp;
            end
        end
    end

    // Per-lane element pick, zero past the length
    for (genvar l = 0; l < NUM_LANES; l++) begin : g_pick
        logic [10:0] eidx;

        assign eidx = 11'(cmp_idx) + 11'(l);

        always_ff @(posedge clk) begin
            if (eidx < 11'(vec_length)) begin
                lane_a[l] <= a_buf[eidx[IDX_W-1:0]];
                lane_b[l] <= b_buf[eidx[IDX_W-1:0]];
            end else begin
                lane_a[l] <= '0;
                lane_b[l] <= '0;
            end
        end
    end

endmodule

// ==== hdl/mac_lane.sv ====
// Registered multiply lane
`timescale 1ns/1ps

module mac_lane (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               op_valid,
    input  logic               op_last,
    input  dot_cfg_pkg::elem_t op_a,
    input  dot_cfg_pkg::elem_t op_b,
    output logic               prod_valid,
    output logic               prod_last,
    output dot_cfg_pkg::acc_t  prod
);
    import dot_cfg_pkg::*;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_valid <= 1'b0;
            prod_last  <= 1'b0;
        end else begin
            prod_valid <= op_valid;
            prod_last  <= op_last;
        end
    end

    // Full signed 32x32 product, sign extended before the multiply
    always_ff @(posedge clk) begin
        prod <= acc_t'(op_a) * acc_t'(op_b);
    end

    // Feeder only flags last on an issued group
    a_last_has_valid: assert property (@(posedge clk) disable iff (!reset_n)
        op_last |-> op_valid);

endmodule

// ==== hdl/lane_reducer.sv ====
// Lane sum and 64-bit accumulator
`timescale 1ns/1ps

module lane_reducer #(
    parameter int NUM_LANES = dot_cfg_pkg::DEFAULT_NUM_LANES
) (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 compute_start,
    input  logic                 result_clear,
    input  logic [NUM_LANES-1:0] prod_valid,
    input  logic [NUM_LANES-1:0] prod_last,
    input  dot_cfg_pkg::acc_t    prod [NUM_LANES],
    output dot_cfg_pkg::acc_t    acc_value,
    output logic                 acc_done
);
    import dot_cfg_pkg::*;

    acc_t group_sum;

    // Adder tree over the lanes, wraps at 64 bits
    always_comb begin
        group_sum = '0;
        for (int l = 0; l < NUM_LANES; l++) begin
            group_sum = group_sum + prod[l];
        end
    end

    // Lane 0 speaks for the group
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            acc_value <= '0;
            acc_done  <= 1'b0;
        end else begin
            acc_done <= prod_valid[0] && prod_last[0];
            if (compute_start || result_clear) begin
                acc_value <= '0;
            end else if (prod_valid[0]) begin
                acc_value <= acc_value + group_sum;
            end
        end
    end

    // All lanes run in lock step
    a_lanes_aligned: assert property (@(posedge clk) disable iff (!reset_n)
        (prod_valid == {NUM_LANES{prod_valid[0]}})
        && (prod_last == {NUM_LANES{prod_last[0]}}));

endmodule

// ==== hdl/dot_product_top.sv ====
// Dot product engine top level
`timescale 1ns/1ps

module dot_product_top #(
    parameter int MAX_LENGTH = dot_cfg_pkg::DEFAULT_MAX_LENGTH,
    parameter int NUM_LANES  = dot_cfg_pkg::DEFAULT_NUM_LANES
) (
    input  logic        clk,
    input  logic        reset_n,
    // Register bus
    input  logic        reg_valid,
    input  logic        reg_write,
    input  logic [7:0]  reg_addr,
    input  logic [31:0] reg_wdata,
    output logic [31:0] reg_rdata,
    output logic        reg_ready,
    // SDRAM burst read port
    output logic        burst_rd,
    output logic [24:0] burst_addr,
    output logic [10:0] burst_len,
    output logic        burst_32bit,
    input  logic [31:0] burst_data,
    input  logic        burst_data_valid,
    input  logic        burst_data_done
);
    import dot_cfg_pkg::*;

    // ==============================
    // Internal wiring
    // ==============================

    logic                 busy;
    logic                 start_req;
    logic [1:0]           ctrl_mode;
    vec_len_t             vec_length;
    word_addr_t           addr_a;
    word_addr_t           addr_b;
    logic                 buf_wr_en;
    logic                 buf_wr_sel_b;
    vec_len_t             buf_wr_idx;
    elem_t                buf_wr_data;
    logic                 compute_start;
    logic                 result_clear;
    logic                 lane_valid;
    logic                 lane_last;
    elem_t                lane_a [NUM_LANES];
    elem_t                lane_b [NUM_LANES];
    logic [NUM_LANES-1:0] prod_valid;
    logic [NUM_LANES-1:0] prod_last;
    acc_t                 prod [NUM_LANES];
    acc_t                 acc_value;
    logic                 acc_done;

    // Word transfers only
    assign burst_32bit = 1'b1;

    dot_reg_block i_dot_reg_block (
        .clk, .reset_n, .reg_valid, .reg_write, .reg_addr, .reg_wdata,
        .reg_rdata, .reg_ready, .busy, .acc_value,
        .start_req, .ctrl_mode, .vec_length, .addr_a, .addr_b
    );

    dot_dma_sequencer #(.MAX_LENGTH(MAX_LENGTH)) i_dot_dma_sequencer (
        .clk, .reset_n, .start_req, .ctrl_mode, .vec_length, .addr_a, .addr_b,
        .burst_data, .burst_data_valid, .burst_data_done, .acc_done,
        .busy, .burst_rd, .burst_addr, .burst_len,
        .buf_wr_en, .buf_wr_sel_b, .buf_wr_idx, .buf_wr_data,
        .compute_start, .result_clear
    );

    operand_feeder #(.MAX_LENGTH(MAX_LENGTH), .NUM_LANES(NUM_LANES)) i_operand_feeder (
        .clk, .reset_n, .buf_wr_en, .buf_wr_sel_b, .buf_wr_idx, .buf_wr_data,
        .compute_start, .vec_length, .lane_valid, .lane_last, .lane_a, .lane_b
    );

    // One multiplier per lane
    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        mac_lane i_mac_lane (
            .clk, .reset_n,
            .op_valid   (lane_valid),
            .op_last    (lane_last),
            .op_a       (lane_a[l]),
            .op_b       (lane_b[l]),
            .prod_valid (prod_valid[l]),
            .prod_last  (prod_last[l]),
            .prod       (prod[l])
        );
    end

    lane_reducer #(.NUM_LANES(NUM_LANES)) i_lane_reducer (
        .clk, .reset_n, .compute_start, .result_clear,
        .prod_valid, .prod_last, .prod, .acc_value, .acc_done
    );

endmodule

// ==== testbench/tb_clock_gen.sv ====
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 10,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic reset_n
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Reset held low over the first rising edges
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;
    end

endmodule

// ==== testbench/tb_dot_product.sv ====
// Dot product engine testbench
`timescale 1ns/1ps

module tb_dot_product;
    import dot_regmap_pkg::*;

    localparam logic [31:0] LFSR_SEED      = 32'h32228c81;
    localparam int          TIMEOUT_CYCLES = 20000;
    localparam logic [31:0] CTRL_GO        = 32'h1 << CTRL_START_BIT;
    localparam logic [31:0] CTRL_CACHED    = CTRL_GO | (32'h1 << CTRL_CACHED_B_BIT);
    localparam logic [31:0] CTRL_PRELOAD   = CTRL_GO | (32'h1 << CTRL_PRELOAD_B_BIT);

    logic        clk;
    logic        reset_n;
    logic        reg_valid;
    logic        reg_write;
    logic [7:0]  reg_addr;
    logic [31:0] reg_wdata;
    logic [31:0] reg_rdata;
    logic        reg_ready;
    logic        burst_rd;
    logic [24:0] burst_addr;
    logic [10:0] burst_len;
    logic        burst_32bit;
    logic [31:0] burst_data;
    logic        burst_data_valid;
    logic        burst_data_done;

    // Requests seen by the SDRAM model and results read back by the CPU
    logic [24:0] req_addr_q[$];
    logic [10:0] req_len_q[$];
    logic [63:0] expected_q[$];
    logic [63:0] result_q[$];
    logic [31:0] lfsr_state;
    int          checks;
    int          mismatch_count;
    int          other_count;

    int          test_lengths[6] = '{1, 2, 7, 16, 33, 512};
    logic [7:0]  mapped_regs[6] = '{REG_CTRL, REG_LENGTH, REG_RESULT_LO,
                                    REG_RESULT_HI, REG_ADDR_A, REG_ADDR_B};
    logic [7:0]  unmapped_regs[4] = '{8'h18, 8'h1C, 8'h40, 8'hFC};

    tb_clock_gen i_tb_clock_gen (.clk, .reset_n);

    dot_product_top i_dot_product_top (
        .clk, .reset_n, .reg_valid, .reg_write, .reg_addr, .reg_wdata,
        .reg_rdata, .reg_ready, .burst_rd, .burst_addr, .burst_len,
        .burst_32bit, .burst_data, .burst_data_valid, .burst_data_done
    );

    // ==============================
    // Models and reference
    // ==============================

    // SDRAM contents mixed from the whole word address
    function automatic logic [31:0] sdram_word(input logic [23:0] w);
        logic [31:0] x;
        x = {8'h00, w} * 32'h9E37_79B1;
        x = x ^ (x >> 13);
        return x ^ {w, 8'hC5};
    endfunction

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
    function automatic logic rand_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    // Expected dot product as signed products summed with 64-bit wrap
    function automatic logic [63:0] dot_ref(input logic [23:0] a, input logic [23:0] b,
                                            input int len);
        logic signed [31:0] ea;
        logic signed [31:0] eb;
        logic signed [63:0] pa;
        logic signed [63:0] pb;
        logic signed [63:0] acc;
        acc = '0;
        for (int i = 0; i < len; i++) begin
            ea  = sdram_word(a + 24'(i));
            eb  = sdram_word(b + 24'(i));
            pa  = ea;
            pb  = eb;
            acc = acc + pa * pb;
        end
        return acc;
    endfunction

    // ==============================
    // Checks and run control
    // ==============================

    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            mismatch_count++;
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond === 1'b1) else begin
            other_count++;
            $display("ERROR: %s", what);
        end
    endtask

    task automatic end_run();
        $display("Checks %0d, mismatches %0d, other errors %0d",
                 checks, mismatch_count, other_count);
        if (mismatch_count + other_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    task automatic timeout_abort(input string what);
        other_count++;
        $display("ERROR: timed out waiting for %s", what);
        end_run();
    endtask

    // ==============================
    // SDRAM burst responder
    // ==============================

    task automatic serve_burst(input logic [23:0] base, input int words);
        int   gap;
        logic split_done;
        // Done either with the last word or one cycle after it
        split_done = (words == 0) || rand_bit();
        for (int k = 0; k < words; k++) begin
            gap = rand_bit() ? 1 : 0;
            if (rand_bit()) begin
                gap = gap + 2;
            end
            repeat (gap) begin
                @(posedge clk);
                burst_data_valid <= 1'b0;
                burst_data_done  <= 1'b0;
            end
            @(posedge clk);
            burst_data_valid <= 1'b1;
            burst_data       <= sdram_word(base + 24'(k));
            burst_data_done  <= (k == words - 1) && !split_done;
        end
        @(posedge clk);
        burst_data_valid <= 1'b0;
        burst_data_done  <= split_done;
        if (split_done) begin
            @(posedge clk);
            burst_data_done <= 1'b0;
        end
    endtask

    initial begin : sdram_responder
        forever begin
            @(negedge clk);
            if (reset_n === 1'b1 && burst_rd === 1'b1) begin
                req_addr_q.push_back(burst_addr);
                req_len_q.push_back(burst_len);
                check_true(burst_32bit, "burst_32bit low during a burst request");
                serve_burst(burst_addr[24:1], int'(burst_len[10:1]));
            end
        end
    end

    // Compare each read back result with its reference value
    always @(negedge clk) begin : compare_results
        logic [63:0] exp_val;
        if (result_q.size() != 0 && expected_q.size() != 0) begin
            exp_val = expected_q.pop_front();
            check_eq("result {RESULT_HI,RESULT_LO}", result_q.pop_front(), exp_val);
        end
    end

    // ==============================
    // CPU register access
    // ==============================

    task automatic cpu_access(input logic wr, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        @(posedge clk);
        reg_valid <= 1'b1;
        reg_write <= wr;
        reg_addr  <= addr;
        reg_wdata <= wdata;
        waited = 0;
        @(negedge clk);
        while (reg_ready !== 1'b1) begin
            if (waited == TIMEOUT_CYCLES) begin
                timeout_abort("reg_ready");
            end
            waited++;
            @(negedge clk);
        end
        rdata = reg_rdata;
        // Access acts on this edge and valid drops with it
        @(posedge clk);
        reg_valid <= 1'b0;
        reg_write <= 1'b0;
    endtask

    task automatic cpu_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        cpu_access(1'b1, addr, data, unused);
    endtask

    task automatic cpu_read(input logic [7:0] addr, output logic [31:0] data);
        cpu_access(1'b0, addr, 32'h0, data);
    endtask

    // Poll the status bit until the engine goes idle
    task automatic wait_idle();
        logic [31:0] status;
        int          polls;
        polls = 0;
        cpu_read(REG_CTRL, status);
        while (status[STATUS_BUSY_BIT] !== 1'b0) begin
            if (polls == TIMEOUT_CYCLES) begin
                timeout_abort("busy to clear");
            end
            polls++;
            cpu_read(REG_CTRL, status);
        end
    endtask

    task automatic run_engine(input logic [31:0] ctrl, input int len, input logic [23:0] a,
                              input logic [23:0] b, input logic [63:0] expected,
                              input logic poke_while_busy);
        logic [31:0] lo;
        logic [31:0] hi;
        req_addr_q.delete();
        req_len_q.delete();
        cpu_write(REG_LENGTH, 32'(len));
        cpu_write(REG_ADDR_A, 32'(a));
        cpu_write(REG_ADDR_B, 32'(b));
        expected_q.push_back(expected);
        cpu_write(REG_CTRL, ctrl);
        if (poke_while_busy) begin
            cpu_read(REG_CTRL, lo);
            check_true(lo[STATUS_BUSY_BIT], "engine not busy right after a start");
            // A preload taken here would wreck the result
            cpu_write(REG_CTRL, CTRL_PRELOAD);
        end
        wait_idle();
        cpu_read(REG_RESULT_LO, lo);
        cpu_read(REG_RESULT_HI, hi);
        result_q.push_back({hi, lo});
    endtask

    // Request count and then address and length of each
    task automatic check_bursts(input int count, input logic [23:0] first_addr,
                                input logic [23:0] second_addr, input int len);
        check_eq("burst request count", 64'(req_addr_q.size()), 64'(count));
        for (int i = 0; i < count && i < req_addr_q.size(); i++) begin
            check_eq("burst_addr", 64'(req_addr_q[i]),
                     64'({(i == 0) ? first_addr : second_addr, 1'b0}));
            check_eq("burst_len", 64'(req_len_q[i]), 64'({10'(len), 1'b0}));
        end
    endtask

    // ==============================
    // Test sequence
    // ==============================

    initial begin : main_test
        logic [31:0] rdata;
        logic [23:0] a;
        logic [23:0] b;
        int          waited;
        reg_valid        = 1'b0;
        reg_write        = 1'b0;
        reg_addr         = '0;
        reg_wdata        = '0;
        burst_data       = '0;
        burst_data_valid = 1'b0;
        burst_data_done  = 1'b0;
        lfsr_state       = LFSR_SEED;
        checks           = 0;
        mismatch_count   = 0;
        other_count      = 0;
        waited           = 0;
        while (reset_n !== 1'b1) begin
            if (waited == TIMEOUT_CYCLES) begin
                timeout_abort("reset release");
            end
            waited++;
            @(negedge clk);
        end

        // Reset state with all registers zero and no bursts
        foreach (mapped_regs[i]) begin
            cpu_read(mapped_regs[i], rdata);
            check_eq($sformatf("reg_rdata at 0x%h", mapped_regs[i]), 64'(rdata), 64'h0);
        end
        check_eq("burst request count", 64'(req_addr_q.size()), 64'h0);

        // Readback truncated to field width
        cpu_write(REG_LENGTH, 32'hFFFF_FC05);
        cpu_read(REG_LENGTH, rdata);
        check_eq("reg_rdata LENGTH", 64'(rdata), 64'h0000_0005);
        cpu_write(REG_ADDR_A, 32'hA512_3456);
        cpu_read(REG_ADDR_A, rdata);
        check_eq("reg_rdata ADDR_A", 64'(rdata), 64'h0012_3456);
        cpu_write(REG_ADDR_B, 32'hFFFF_FFFF);
        cpu_read(REG_ADDR_B, rdata);
        check_eq("reg_rdata ADDR_B", 64'(rdata), 64'h00FF_FFFF);
        cpu_write(8'h18, 32'hDEAD_BEEF);
        foreach (unmapped_regs[i]) begin
            cpu_read(unmapped_regs[i], rdata);
            check_eq($sformatf("reg_rdata at 0x%h", unmapped_regs[i]), 64'(rdata), 64'h0);
        end

        // Normal mode over several lengths
        foreach (test_lengths[i]) begin
            a = 24'h010000 + 24'(i * 'h1000);
            b = 24'h200000 + 24'(i * 'h0C00);
            run_engine(CTRL_GO, test_lengths[i], a, b, dot_ref(a, b, test_lengths[i]), 1'b0);
            check_bursts(2, a, b, test_lengths[i]);
        end

        // Preload B then reuse it with ADDR_B moved away in between
        b = 24'h3A0000;
        run_engine(CTRL_PRELOAD, 45, 24'h000100, b, 64'h0, 1'b0);
        check_bursts(1, b, b, 45);
        a = 24'h123400;
        run_engine(CTRL_CACHED, 45, a, 24'h7F0000, dot_ref(a, b, 45), 1'b0);
        check_bursts(1, a, a, 45);

        // Start while busy
        a = 24'h004000;
        b = 24'h005800;
        run_engine(CTRL_GO, 64, a, b, dot_ref(a, b, 64), 1'b1);
        check_bursts(2, a, b, 64);

        waited = 0;
        while (result_q.size() != 0) begin
            if (waited == TIMEOUT_CYCLES) begin
                timeout_abort("result compare");
            end
            waited++;
            @(negedge clk);
        end
        end_run();
    end

endmodule

// ==== sources.f ====
hdl/dot_cfg_pkg.sv
hdl/dot_regmap_pkg.sv
hdl/dot_reg_block.sv
hdl/dot_dma_sequencer.sv
hdl/operand_feeder.sv
hdl/mac_lane.sv
hdl/lane_reducer.sv
hdl/dot_product_top.sv
testbench/tb_clock_gen.sv
testbench/tb_dot_product.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dot_product
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
